/* rtl/eeprom_pkg.sv */
package eeprom_pkg;

    // 24C16 style part, 2 KB
    localparam int EEPROM_AW = 11;

    // device type code at the top of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // commands from sequencer to bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,   // start or repeated start
        CMD_STOP  = 2'd1,
        CMD_SEND  = 2'd2,   // byte out, ack sampled
        CMD_RECV  = 2'd3    // byte in, master nack
    } i2c_cmd_e;

    // memory address
    // flat index on the host side, block/word when building bus bytes
    typedef union packed {
        logic [EEPROM_AW-1:0] index;
        struct packed {
            logic [2:0] block;  // goes into the control byte
            logic [7:0] word;   // word address byte
        } bw;
    } eeprom_addr_u;

endpackage

/* rtl/i2c_bit_engine.sv */
`timescale 1ns/10ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_go,
    input  eeprom_pkg::i2c_cmd_e cmd,
    input  logic [7:0]           tx_byte,
    input  logic                 sda_in,
    output logic                 cmd_done,
    output logic [7:0]           rx_byte,
    output logic                 rx_ack,
    output logic                 scl,
    output logic                 sda_pull
);

    localparam int DW = $clog2(CLK_DIV);

    logic                 active;
    eeprom_pkg::i2c_cmd_e cur_cmd;
    logic [DW-1:0]        div_cnt;
    logic [1:0]           quarter;
    logic [1:0]           next_q;
    logic [3:0]           bit_cnt;
    logic [3:0]           next_bit;
    logic                 quarter_end;
    logic                 last_bit;
    logic                 sample;
    logic [7:0]           shreg;

    // pull-down wanted on sda for a command in a given quarter and bit
    function automatic logic pull_for(
        input eeprom_pkg::i2c_cmd_e c,
        input logic [1:0]           q,
        input logic [3:0]           b,
        input logic                 d
    );
        logic p;
        case (c)
            eeprom_pkg::CMD_START: p = (q == 2'd3);         // falls with scl high
            eeprom_pkg::CMD_STOP:  p = (q != 2'd3);         // rises with scl high
            eeprom_pkg::CMD_SEND:  p = (b != 4'd8) && !d;   // ack slot released
            default:               p = 1'b0;                // receive, then nack
        endcase
        return p;
    endfunction

    assign quarter_end = active && (div_cnt == DW'(CLK_DIV - 1));
    assign next_q      = quarter + 2'd1;
    assign next_bit    = (quarter == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;

    // start and stop are a single bit time
    assign last_bit = (cur_cmd == eeprom_pkg::CMD_START) ||
                      (cur_cmd == eeprom_pkg::CMD_STOP) ||
                      (bit_cnt == 4'd8);

    assign sample   = active && (quarter == 2'd3) && (div_cnt == '0);
    assign cmd_done = quarter_end && (quarter == 2'd3) && last_bit;
    assign rx_byte  = shreg;

    // quarter timing and line drive
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            cur_cmd  <= eeprom_pkg::CMD_STOP;
            div_cnt  <= '0;
            quarter  <= 2'd0;
            bit_cnt  <= 4'd0;
            scl      <= 1'b1;
            sda_pull <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_go)
            begin
                active   <= 1'b1;
                cur_cmd  <= cmd;
                div_cnt  <= '0;
                quarter  <= 2'd0;
                bit_cnt  <= 4'd0;
                scl      <= 1'b0;   // quarter 0 is scl low
                sda_pull <= pull_for(cmd, 2'd0, 4'd0, tx_byte[7]);
            end
        end
        else if (quarter_end)
        begin
            div_cnt <= '0;
            quarter <= next_q;
            bit_cnt <= next_bit;
            if ((quarter == 2'd3) && last_bit)
                active <= 1'b0;     // lines hold until the next command
            else
            begin
                scl      <= next_q[1];
                sda_pull <= pull_for(cur_cmd, next_q, next_bit, shreg[7]);
            end
        end
        else
            div_cnt <= div_cnt + DW'(1);
    end

    // data bits shift out msb first, the line value shifts back in behind them
    // so after eight bits of a receive the register holds the byte read
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_go)
            shreg <= tx_byte;
        else if (sample)
        begin
            if (bit_cnt == 4'd8)
                rx_ack <= !sda_in;  // low on the line means acknowledged
            else
                shreg <= {shreg[6:0], sda_in};
        end
    end

endmodule

/* rtl/eeprom_sequencer.sv */
`timescale 1ns/10ps

module eeprom_sequencer (
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             wr,
    input  logic                             rd,
    input  logic [eeprom_pkg::EEPROM_AW-1:0] addr,
    input  logic [7:0]                       wdata,
    input  logic                             cmd_done,
    input  logic [7:0]                       rx_byte,
    input  logic                             rx_ack,
    output logic                             cmd_go,
    output eeprom_pkg::i2c_cmd_e             cmd,
    output logic [7:0]                       tx_byte,
    output logic [7:0]                       rdata,
    output logic                             done,
    output logic                             busy,
    output logic                             ack_err
);

    localparam logic [8:0] ST_IDLE   = 9'b0_0000_0001;
    localparam logic [8:0] ST_START  = 9'b0_0000_0010;
    localparam logic [8:0] ST_CTRL_W = 9'b0_0000_0100;
    localparam logic [8:0] ST_WORD   = 9'b0_0000_1000;
    localparam logic [8:0] ST_DATA_W = 9'b0_0001_0000;
    localparam logic [8:0] ST_RSTART = 9'b0_0010_0000;
    localparam logic [8:0] ST_CTRL_R = 9'b0_0100_0000;
    localparam logic [8:0] ST_DATA_R = 9'b0_1000_0000;
    localparam logic [8:0] ST_STOP   = 9'b1_0000_0000;

    logic [8:0]               state;
    logic [8:0]               next_state;
    logic                     accept;
    logic                     issue;
    logic                     send_state;
    logic                     nack;
    eeprom_pkg::i2c_cmd_e     next_cmd;
    logic [7:0]               next_tx;
    logic                     is_read;
    eeprom_pkg::eeprom_addr_u addr_q;
    logic [7:0]               wdata_q;
    logic [7:0]               ctrl_wr;
    logic [7:0]               ctrl_rd;

    // busy covers the done cycle, so a strobe then is dropped
    assign busy   = (state != ST_IDLE) || done;
    assign accept = !busy && (wr || rd);

    assign ctrl_wr = {eeprom_pkg::DEV_CODE, addr_q.bw.block, 1'b0};
    assign ctrl_rd = {eeprom_pkg::DEV_CODE, addr_q.bw.block, 1'b1};

    // states that sent a byte and expect an ack
    assign send_state = |(state & (ST_CTRL_W | ST_WORD | ST_DATA_W | ST_CTRL_R));
    assign nack       = cmd_done && send_state && !rx_ack;

    always_comb
    begin
        next_state = state;
        issue      = 1'b0;
        next_cmd   = eeprom_pkg::CMD_STOP;
        next_tx    = ctrl_wr;
        case (state)
            ST_IDLE:
                if (accept)
                begin
                    next_state = ST_START;
                    issue      = 1'b1;
                    next_cmd   = eeprom_pkg::CMD_START;
                end
            ST_START:
                if (cmd_done)
                begin
                    next_state = ST_CTRL_W;
                    issue      = 1'b1;
                    next_cmd   = eeprom_pkg::CMD_SEND;
                end
            ST_CTRL_W:
                if (cmd_done)
                begin
                    next_state = ST_WORD;
                    issue      = 1'b1;
                    next_cmd   = eeprom_pkg::CMD_SEND;
                    next_tx    = addr_q.bw.word;
                end
            ST_WORD:
                if (cmd_done)
                begin
                    issue = 1'b1;
                    if (is_read)
                    begin
                        next_state = ST_RSTART;
                        next_cmd   = eeprom_pkg::CMD_START;
                    end
                    else
                    begin
                        next_state = ST_DATA_W;
                        next_cmd   = eeprom_pkg::CMD_SEND;
                        next_tx    = wdata_q;
                    end
                end
            ST_RSTART:
                if (cmd_done)
                begin
                    next_state = ST_CTRL_R;
                    issue      = 1'b1;
                    next_cmd   = eeprom_pkg::CMD_SEND;
                    next_tx    = ctrl_rd;
                end
            ST_CTRL_R:
                if (cmd_done)
                begin
                    next_state = ST_DATA_R;
                    issue      = 1'b1;
                    next_cmd   = eeprom_pkg::CMD_RECV;
                end
            ST_DATA_W, ST_DATA_R:
                if (cmd_done)
                begin
                    next_state = ST_STOP;
                    issue      = 1'b1;
                end
            ST_STOP:
                if (cmd_done)
                    next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase

        // missing ack, abort with a stop
        if (nack)
        begin
            next_state = ST_STOP;
            issue      = 1'b1;
            next_cmd   = eeprom_pkg::CMD_STOP;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            cmd_go  <= 1'b0;
            done    <= 1'b0;
            ack_err <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            cmd_go <= issue;
            done   <= (state == ST_STOP) && cmd_done;
            if (accept)
                ack_err <= 1'b0;
            else if (nack)
                ack_err <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_read      <= !wr;    // wr wins
            addr_q.index <= addr;
            wdata_q      <= wdata;
        end
        if (issue)
        begin
            cmd     <= next_cmd;
            tx_byte <= next_tx;
        end
        if ((state == ST_DATA_R) && cmd_done)
            rdata <= rx_byte;
    end

endmodule

/* rtl/eeprom_ctrl_top.sv */
`timescale 1ns/10ps

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4   // clk cycles per quarter scl period
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_u addr,
    input  logic [7:0]               wdata,
    input  logic                     sda_in,
    output logic [7:0]               rdata,
    output logic                     done,
    output logic                     busy,
    output logic                     ack_err,
    output logic                     scl,
    output logic                     sda_pull
);

    logic                 cmd_go;
    eeprom_pkg::i2c_cmd_e cmd;
    logic [7:0]           tx_byte;
    logic                 cmd_done;
    logic [7:0]           rx_byte;
    logic                 rx_ack;

    eeprom_sequencer seq0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr.index),
        .wdata    (wdata),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .rx_ack   (rx_ack),
        .cmd_go   (cmd_go),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .rdata    (rdata),
        .done     (done),
        .busy     (busy),
        .ack_err  (ack_err)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) eng0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .cmd_go   (cmd_go),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .sda_in   (sda_in),
        .cmd_done (cmd_done),
        .rx_byte  (rx_byte),
        .rx_ack   (rx_ack),
        .scl      (scl),
        .sda_pull (sda_pull)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int HALF_PERIOD = 10  // ns, 20 ns period
) (
    output logic CLK
);

    initial
        CLK = 1'b0;

    always #(HALF_PERIOD) CLK = ~CLK;

endmodule

/* tb/eeprom_model.sv */
`timescale 1ns/10ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,        // resolved line
    input  logic nack_ctrl,  // refuse every control byte
    output logic sda_pull
);

    localparam logic [2:0] M_IDLE = 3'd0;
    localparam logic [2:0] M_CTRL = 3'd1;
    localparam logic [2:0] M_WORD = 3'd2;
    localparam logic [2:0] M_DATA = 3'd3;
    localparam logic [2:0] M_READ = 3'd4;

    logic [7:0]               mem [0:2047];
    logic [2:0]               phase;
    logic [3:0]               bit_cnt;
    logic                     ack_slot;
    logic [7:0]               shreg;
    eeprom_pkg::eeprom_addr_u ptr;
    logic                     scl_q;
    logic                     sda_q;
    logic                     rise;
    logic                     fall;
    logic                     start_c;
    logic                     stop_c;

    // bus seen through CLK samples, so scl and sda moving together is no start or stop
    assign rise    = !scl_q && scl;
    assign fall    = scl_q && !scl;
    assign start_c = scl_q && scl && sda_q && !sda;
    assign stop_c  = scl_q && scl && !sda_q && sda;

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            phase    <= M_IDLE;
            bit_cnt  <= 4'd0;
            ack_slot <= 1'b0;
            sda_pull <= 1'b0;
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'(i) ^ 8'ha5;
        end
        else if (start_c)
        begin
            phase    <= M_CTRL;
            bit_cnt  <= 4'd0;
            ack_slot <= 1'b0;
            sda_pull <= 1'b0;
        end
        else if (stop_c)
        begin
            phase    <= M_IDLE;
            ack_slot <= 1'b0;
            sda_pull <= 1'b0;
        end
        else if (phase != M_IDLE)
        begin
            if (rise && !ack_slot)
            begin
                if (phase == M_READ)
                begin
                    if (bit_cnt == 4'd8)
                        phase <= M_IDLE;    // master ack clock, single byte only
                    else
                        bit_cnt <= bit_cnt + 4'd1;
                end
                else
                begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else if (fall && ack_slot)
            begin
                ack_slot <= 1'b0;
                bit_cnt  <= 4'd0;
                if (phase == M_READ)
                begin
                    shreg    <= mem[ptr.index];
                    sda_pull <= !mem[ptr.index][7];
                end
                else
                    sda_pull <= 1'b0;
            end
            else if (fall && (phase == M_READ))
            begin
                if (bit_cnt == 4'd8)
                    sda_pull <= 1'b0;       // let the master answer
                else
                begin
                    sda_pull <= !shreg[6];
                    shreg    <= {shreg[6:0], 1'b0};
                end
            end
            else if (fall && (bit_cnt == 4'd8))
            begin
                if ((phase == M_CTRL) && ((shreg[7:4] != eeprom_pkg::DEV_CODE) || nack_ctrl))
                    phase <= M_IDLE;        // no ack, line stays released
                else
                begin
                    ack_slot <= 1'b1;
                    sda_pull <= 1'b1;
                    case (phase)
                        M_CTRL:
                        begin
                            ptr.bw.block <= shreg[3:1];
                            phase        <= shreg[0] ? M_READ : M_WORD;
                        end
                        M_WORD:
                        begin
                            ptr.bw.word <= shreg;
                            phase       <= M_DATA;
                        end
                        default:
                            mem[ptr.index] <= shreg;
                    endcase
                end
            end
        end
    end

endmodule

/* tb/eeprom_ctrl_checker.sv */
`timescale 1ns/10ps

module eeprom_ctrl_checker (
    input logic CLK,
    input logic RESET,
    input logic busy,
    input logic done,
    input logic scl,
    input logic sda_pull
);

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done held for more than one cycle");

    // done closes a transaction already running
    done_in_busy: assert property (@(posedge CLK) disable iff (RESET) done |-> $past(busy))
        else $error("done seen without a transaction in flight");

    // bus idle whenever the controller is
    bus_idle: assert property (@(posedge CLK) disable iff (RESET) !busy |-> (scl && !sda_pull))
        else $error("bus not idle while not busy");

    busy_drop: assert property (@(posedge CLK) disable iff (RESET) done |=> !busy)
        else $error("busy still high the cycle after done");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_checker chk0 (
    .CLK      (CLK),
    .RESET    (RESET),
    .busy     (busy),
    .done     (done),
    .scl      (scl),
    .sda_pull (sda_pull)
);

/* tb/tb_eeprom.sv */
`timescale 1ns/10ps

module tb_eeprom;

    localparam int CLK_DIV  = 4;
    localparam int N_WRITES = 30;
    localparam int N_FRESH  = 8;
    localparam int N_TRANS  = 2 * N_WRITES + N_FRESH + 8 + 2 + 2;  // quiet window counted once
    localparam int LIMIT    = N_TRANS * 40 * 4 * CLK_DIV * 2;

    logic                     CLK;
    logic                     RESET;
    logic                     wr;
    logic                     rd;
    eeprom_pkg::eeprom_addr_u addr;
    logic [7:0]               wdata;
    logic                     sda_in;
    logic [7:0]               rdata;
    logic                     done;
    logic                     busy;
    logic                     ack_err;
    logic                     scl;
    logic                     sda_pull;
    logic                     model_pull;
    logic                     nack_ctrl;

    logic [7:0]  shadow [0:2047];
    logic        written [0:2047];
    logic [31:0] lfsr_state = 32'hc69f;
    int          errors;
    int          checks;
    int          test_errs;
    int          tests;
    int          done_cnt;
    int          cycle_cnt;

    tb_clock clk0 (.CLK(CLK));

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) dut0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .sda_in   (sda_in),
        .rdata    (rdata),
        .done     (done),
        .busy     (busy),
        .ack_err  (ack_err),
        .scl      (scl),
        .sda_pull (sda_pull)
    );

    eeprom_model model0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_in),
        .nack_ctrl (nack_ctrl),
        .sda_pull  (model_pull)
    );

    assign sda_in = !(sda_pull || model_pull);  // wired-AND, pull-up

    always @(posedge CLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT)
        begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    always @(negedge CLK)
        if (!RESET && done)
            done_cnt <= done_cnt + 1;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_addr_byte(input eeprom_pkg::eeprom_addr_u a, input logic [7:0] exp);
        checks++;
        if (model0.mem[a.index] !== exp)
        begin
            $display("Mismatch mem[%h]: got %h expected %h", a.index, model0.mem[a.index], exp);
            test_errs++;
        end
    endtask

    task automatic send_request(input logic is_wr, input eeprom_pkg::eeprom_addr_u a,
                                input logic [7:0] d);
        @(posedge CLK);
        #2;
        wr    = is_wr;
        rd    = !is_wr;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done;
        do
        begin
            @(posedge CLK);
            #1;
        end
        while (!done);
    endtask

    task automatic write_byte(input eeprom_pkg::eeprom_addr_u a, input logic [7:0] d);
        send_request(1'b1, a, d);
        wait_done;
        check_flag("ack_err", ack_err, 1'b0);
        shadow[a.index]  = d;
        written[a.index] = 1'b1;
    endtask

    task automatic read_byte(input eeprom_pkg::eeprom_addr_u a, input logic [7:0] exp);
        send_request(1'b0, a, 8'h00);
        wait_done;
        check_flag("ack_err", ack_err, 1'b0);
        check_byte("rdata", rdata, exp);
    endtask

    task automatic report_test(input string name);
        tests++;
        errors += test_errs;
        if (test_errs == 0)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, test_errs);
        test_errs = 0;
    endtask

    initial
    begin
        eeprom_pkg::eeprom_addr_u a;
        eeprom_pkg::eeprom_addr_u b;
        eeprom_pkg::eeprom_addr_u list [N_WRITES];
        logic [7:0]               blk_data [8];
        logic [7:0]               d;
        logic [7:0]               w;
        int                       n;

        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = 8'h00;
        nack_ctrl = 1'b0;
        for (int i = 0; i < 2048; i++)
        begin
            shadow[i]  = 8'(i) ^ 8'ha5;  // same preload as the part
            written[i] = 1'b0;
        end
        repeat (8) @(posedge CLK);
        #2;
        RESET = 1'b0;

        @(posedge CLK);
        #1;
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("ack_err", ack_err, 1'b0);
        check_flag("sda_pull", sda_pull, 1'b0);
        check_flag("scl", scl, 1'b1);
        report_test("idle after reset");

        for (int i = 0; i < N_WRITES; i++)
        begin
            list[i].index = 11'(rand_bits(11));
            write_byte(list[i], 8'(rand_bits(8)));
        end
        for (int i = 0; i < N_WRITES; i++)
            read_byte(list[i], shadow[list[i].index]);
        report_test("random writes read back");

        for (int i = 0; i < N_FRESH; i++)
        begin
            do
                a.index = 11'(rand_bits(11));
            while (written[a.index]);
            read_byte(a, a.index[7:0] ^ 8'ha5);
        end
        report_test("unwritten reads");

        // same word in every block, data tagged with the block
        w = 8'(rand_bits(8));
        for (int blk = 0; blk < 8; blk++)
        begin
            a.bw.block    = 3'(blk);
            a.bw.word     = w;
            blk_data[blk] = {5'(rand_bits(5)), 3'(blk)};
            write_byte(a, blk_data[blk]);
        end
        for (int blk = 0; blk < 8; blk++)
        begin
            b.index = 11'(blk * 256 + int'(w));
            check_addr_byte(b, blk_data[blk]);
        end
        report_test("block addressing");

        a.index = 11'(rand_bits(11));
        @(posedge CLK);
        #2;
        nack_ctrl = 1'b1;
        send_request(1'b1, a, ~shadow[a.index]);
        wait_done;
        check_flag("ack_err", ack_err, 1'b1);
        check_addr_byte(a, shadow[a.index]);
        send_request(1'b0, a, 8'h00);
        wait_done;
        check_flag("ack_err", ack_err, 1'b1);
        @(posedge CLK);
        #2;
        nack_ctrl = 1'b0;
        report_test("missing ack");

        a.index = 11'(rand_bits(11));
        b.index = a.index ^ 11'h400;
        d       = 8'(rand_bits(8));
        n       = done_cnt;
        send_request(1'b1, a, d);
        repeat (10) @(posedge CLK);
        #1;
        check_flag("busy", busy, 1'b1);
        send_request(1'b1, b, ~shadow[b.index]);
        send_request(1'b0, a, 8'h00);
        wait_done;
        shadow[a.index] = d;
        repeat (40 * 4 * CLK_DIV) @(posedge CLK);   // longer than any transaction
        #1;
        checks++;
        if (done_cnt != n + 1)
        begin
            $display("strobes while busy gave %0d done pulses instead of one", done_cnt - n);
            test_errs++;
        end
        check_addr_byte(a, d);
        check_addr_byte(b, shadow[b.index]);
        report_test("strobes while busy");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* sim.f */
rtl/eeprom_pkg.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_ctrl_top.sv
tb/tb_clock.sv
tb/eeprom_model.sv
tb/eeprom_ctrl_checker.sv
tb/tb_eeprom.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulation output
run: compile
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
